//--- include/branch_settings.svh
`ifndef BRANCH_SETTINGS_SVH
`define BRANCH_SETTINGS_SVH

// ----------------------------------------
// Address and opcode widths
// ----------------------------------------

// Instruction address, word granular
`define ADDR_WIDTH 16

// Jump opcode field from decode
`define JUMP_BITS 4

// ----------------------------------------
// Pipeline flush
// ----------------------------------------

// One bit per pipeline register: PC, IF/ID, ID/EX, EX/MEM
`define NUM_PIPE_MASKS 4

// ----------------------------------------
// Branch target table
// ----------------------------------------

// Power of two, indexed by the low pc bits
`define LUT_ENTRIES 16

`endif

//--- hdl/branch_pkg.sv
`default_nettype none

`include "branch_settings.svh"

package branch_pkg;

  // ----------------------------------------
  // Jump opcodes
  // ----------------------------------------

  typedef enum logic [`JUMP_BITS-1:0] {
    JMP_OP_NOP = 4'd0,  // Not a jump
    JMP_OP_J   = 4'd1,  // Immediate, already taken in decode
    JMP_OP_JR  = 4'd2,  // Target from register file
    JMP_OP_JEQ = 4'd3,
    JMP_OP_JNE = 4'd4,
    JMP_OP_JL  = 4'd5,
    JMP_OP_JLE = 4'd6,
    JMP_OP_JG  = 4'd7,
    JMP_OP_JGE = 4'd8,
    JMP_OP_JZ  = 4'd9,
    JMP_OP_JNZ = 4'd10
  } jmp_op_e;

  // ----------------------------------------
  // Flush mask bits
  // ----------------------------------------

  localparam logic [`NUM_PIPE_MASKS-1:0] PIPE_REG_PC     = 4'b0001;
  localparam logic [`NUM_PIPE_MASKS-1:0] PIPE_REG_IF_ID  = 4'b0010;
  localparam logic [`NUM_PIPE_MASKS-1:0] PIPE_REG_ID_EX  = 4'b0100;
  localparam logic [`NUM_PIPE_MASKS-1:0] PIPE_REG_EX_MEM = 4'b1000;

  // Full redirect, everything behind execute is wrong-path
  localparam logic [`NUM_PIPE_MASKS-1:0] PIPE_FLUSH_ALL =
    PIPE_REG_PC | PIPE_REG_IF_ID | PIPE_REG_ID_EX | PIPE_REG_EX_MEM;

endpackage

`default_nettype wire

//--- hdl/target_lut.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_settings.svh"

module target_lut (
  input  logic                   clk,
  input  logic                   rst,

  // Update from branch resolution
  input  logic                   write,
  input  logic                   write_valid,
  input  logic [`ADDR_WIDTH-1:0] write_key,
  input  logic [`ADDR_WIDTH-1:0] write_val,

  // Lookup at fetch
  input  logic [`ADDR_WIDTH-1:0] read_key,
  output logic [`ADDR_WIDTH-1:0] read_val,
  output logic                   read_valid
);

  localparam int INDEX_BITS = $clog2(`LUT_ENTRIES);
  localparam int TAG_BITS   = `ADDR_WIDTH - INDEX_BITS;

  logic                   valid_q  [`LUT_ENTRIES];
  logic [TAG_BITS-1:0]    tag_q    [`LUT_ENTRIES];
  logic [`ADDR_WIDTH-1:0] target_q [`LUT_ENTRIES];

  logic [INDEX_BITS-1:0] write_index;
  logic [TAG_BITS-1:0]   write_tag;
  logic [INDEX_BITS-1:0] read_index;
  logic [TAG_BITS-1:0]   read_tag;

  assign write_index = write_key[INDEX_BITS-1:0];
  assign write_tag   = write_key[`ADDR_WIDTH-1:INDEX_BITS];
  assign read_index  = read_key[INDEX_BITS-1:0];
  assign read_tag    = read_key[`ADDR_WIDTH-1:INDEX_BITS];

  // ----------------------------------------
  // Write port
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `LUT_ENTRIES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (write) begin
      valid_q[write_index] <= write_valid;  // Not-taken mispredict clears
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      tag_q[write_index]    <= write_tag;
      target_q[write_index] <= write_val;
    end
  end

  // ----------------------------------------
  // Read port
  // ----------------------------------------

  // Hit needs both valid and full tag match
  assign read_valid = valid_q[read_index] && (tag_q[read_index] == read_tag);
  assign read_val   = target_q[read_index];

endmodule

`default_nettype wire

//--- hdl/branch_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_settings.svh"

module branch_unit
  import branch_pkg::*;
(
  // ALU flags for the instruction in execute
  input  logic                      zero,
  input  logic                      less,
  input  logic                      greater,

  input  logic                      branch_taken,  // Prediction made at fetch
  input  jmp_op_e                   jop,

  input  logic [`ADDR_WIDTH-1:0]    id_ex_pc,
  input  logic [`ADDR_WIDTH-1:0]    id_ex_reg_address,
  input  logic [`ADDR_WIDTH-1:0]    id_ex_imm_address,

  output logic [`NUM_PIPE_MASKS-1:0] flush,
  output logic [`ADDR_WIDTH-1:0]    jump_address,

  // Table update
  output logic                      lut_write,
  output logic                      lut_write_valid
);

  logic is_cond;     // Conditional jump in execute
  logic cond;        // Real outcome of that jump
  logic mispredict;

  // ----------------------------------------
  // Condition decode
  // ----------------------------------------

  always_comb begin
    is_cond = 1'b1;
    cond    = 1'b0;
    case (jop)
      JMP_OP_JEQ, JMP_OP_JZ:  cond = zero;
      JMP_OP_JNE, JMP_OP_JNZ: cond = !zero;
      JMP_OP_JL:  cond = less;
      JMP_OP_JLE: cond = less || zero;
      JMP_OP_JG:  cond = greater;
      JMP_OP_JGE: cond = greater || zero;
      default:    is_cond = 1'b0;  // NOP, J, JR, unused codes
    endcase
  end

  assign mispredict = is_cond && (cond != branch_taken);

  // ----------------------------------------
  // Flush mask
  // ----------------------------------------

  always_comb begin
    case (jop)
      JMP_OP_NOP: flush = '0;
      JMP_OP_J:   flush = PIPE_REG_EX_MEM;  // Decode already redirected
      JMP_OP_JR:  flush = PIPE_FLUSH_ALL;
      default:    flush = mispredict ? PIPE_FLUSH_ALL : '0;
    endcase
  end

  // ----------------------------------------
  // Redirect address
  // ----------------------------------------

  always_comb begin
    if (jop == JMP_OP_JR) begin
      jump_address = id_ex_reg_address;
    end else if (mispredict && branch_taken) begin
      jump_address = id_ex_pc + `ADDR_WIDTH'(1);  // Back to fall-through
    end else begin
      jump_address = id_ex_imm_address;
    end
  end

  // Every full flush teaches the table
  assign lut_write = (flush == PIPE_FLUSH_ALL);

  // Entry stays valid only when the jump really went
  assign lut_write_valid = (jop == JMP_OP_JR) || (mispredict && !branch_taken);

endmodule

`default_nettype wire

//--- hdl/fetch_pc.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_settings.svh"

module fetch_pc
  import branch_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,

  // Redirect from execute
  input  logic [`NUM_PIPE_MASKS-1:0] flush,
  input  logic [`ADDR_WIDTH-1:0]     jump_address,

  // Prediction from the target table
  input  logic                       take_branch,
  input  logic [`ADDR_WIDTH-1:0]     branch_predict,

  output logic [`ADDR_WIDTH-1:0]     pc
);

  logic                   redirect;
  logic [`ADDR_WIDTH-1:0] pc_next;

  // Only the PC bit of the mask moves fetch
  assign redirect = (flush & PIPE_REG_PC) != '0;

  // ----------------------------------------
  // Next address select
  // ----------------------------------------

  always_comb begin
    if (redirect) begin
      pc_next = jump_address;        // Execute outranks the guess
    end else if (take_branch) begin
      pc_next = branch_predict;
    end else begin
      pc_next = pc + `ADDR_WIDTH'(1);
    end
  end

  // ----------------------------------------
  // PC register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

//--- hdl/branch_frontend.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_settings.svh"

module branch_frontend
  import branch_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,

  // Instruction in execute
  input  jmp_op_e                    jop,
  input  logic                       zero,
  input  logic                       less,
  input  logic                       greater,
  input  logic                       branch_taken,
  input  logic [`ADDR_WIDTH-1:0]     id_ex_pc,
  input  logic [`ADDR_WIDTH-1:0]     id_ex_reg_address,
  input  logic [`ADDR_WIDTH-1:0]     id_ex_imm_address,

  // Fetch side
  output logic [`ADDR_WIDTH-1:0]     pc,
  output logic                       take_branch,
  output logic [`ADDR_WIDTH-1:0]     branch_predict,

  // To the pipeline registers
  output logic [`NUM_PIPE_MASKS-1:0] flush,
  output logic [`ADDR_WIDTH-1:0]     jump_address
);

  logic lut_write;
  logic lut_write_valid;

  fetch_pc u_fetch_pc (
    .clk            (clk),
    .rst            (rst),
    .flush          (flush),
    .jump_address   (jump_address),
    .take_branch    (take_branch),
    .branch_predict (branch_predict),
    .pc             (pc)
  );

  // Read at fetch pc, written with the execute pc
  target_lut u_target_lut (
    .clk         (clk),
    .rst         (rst),
    .write       (lut_write),
    .write_valid (lut_write_valid),
    .write_key   (id_ex_pc),
    .write_val   (jump_address),
    .read_key    (pc),
    .read_val    (branch_predict),
    .read_valid  (take_branch)
  );

  branch_unit u_branch_unit (
    .zero              (zero),
    .less              (less),
    .greater           (greater),
    .branch_taken      (branch_taken),
    .jop               (jop),
    .id_ex_pc          (id_ex_pc),
    .id_ex_reg_address (id_ex_reg_address),
    .id_ex_imm_address (id_ex_imm_address),
    .flush             (flush),
    .jump_address      (jump_address),
    .lut_write         (lut_write),
    .lut_write_valid   (lut_write_valid)
  );

endmodule

`default_nettype wire

//--- tb/tb_branch_frontend.sv
`timescale 1ns/1ns
`default_nettype none

`include "branch_settings.svh"

module tb_branch_frontend
  import branch_pkg::*;
();

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 16;
  localparam int SEQ_CYCLES      = 20;
  localparam int NUM_RANDOM      = 300;
  localparam int DIRECTED_CYCLES = 60;
  localparam int TIMEOUT_NS =
    (RESET_CYCLES + SEQ_CYCLES + NUM_RANDOM + DIRECTED_CYCLES) * CLK_PERIOD + 4000;

  localparam int INDEX_BITS = $clog2(`LUT_ENTRIES);
  localparam int TAG_BITS   = `ADDR_WIDTH - INDEX_BITS;

  localparam logic [`ADDR_WIDTH-1:0] ADDR_ONE  = {{(`ADDR_WIDTH-1){1'b0}}, 1'b1};
  localparam logic [`ADDR_WIDTH-1:0] LEARN_PC  = 16'h0345;
  localparam logic [`ADDR_WIDTH-1:0] TARGET    = 16'h1200;
  localparam logic [`ADDR_WIDTH-1:0] ALIAS_PC  = 16'h7345;  // Same index as LEARN_PC
  localparam logic [`ADDR_WIDTH-1:0] JR_SITE   = 16'h0ff8;

  logic                       clk;
  logic                       rst;
  jmp_op_e                    jop;
  logic                       zero;
  logic                       less;
  logic                       greater;
  logic                       branch_taken;
  logic [`ADDR_WIDTH-1:0]     id_ex_pc;
  logic [`ADDR_WIDTH-1:0]     id_ex_reg_address;
  logic [`ADDR_WIDTH-1:0]     id_ex_imm_address;
  logic [`ADDR_WIDTH-1:0]     pc;
  logic                       take_branch;
  logic [`ADDR_WIDTH-1:0]     branch_predict;
  logic [`NUM_PIPE_MASKS-1:0] flush;
  logic [`ADDR_WIDTH-1:0]     jump_address;

  string       test_name;
  logic [31:0] lfsr_state;

  // Shadow of the target table
  logic                   shadow_valid  [`LUT_ENTRIES];
  logic [TAG_BITS-1:0]    shadow_tag    [`LUT_ENTRIES];
  logic [`ADDR_WIDTH-1:0] shadow_target [`LUT_ENTRIES];

  logic [`ADDR_WIDTH-1:0]     exp_pc;
  logic [`NUM_PIPE_MASKS-1:0] exp_flush;
  logic [`ADDR_WIDTH-1:0]     exp_jump;
  logic                       exp_take;
  logic [`ADDR_WIDTH-1:0]     exp_predict;
  logic                       mispredicted;
  logic [INDEX_BITS-1:0]      rd_idx;
  logic [INDEX_BITS-1:0]      wr_idx;

  branch_frontend u_branch_frontend (
    .clk               (clk),
    .rst               (rst),
    .jop               (jop),
    .zero              (zero),
    .less              (less),
    .greater           (greater),
    .branch_taken      (branch_taken),
    .id_ex_pc          (id_ex_pc),
    .id_ex_reg_address (id_ex_reg_address),
    .id_ex_imm_address (id_ex_imm_address),
    .pc                (pc),
    .take_branch       (take_branch),
    .branch_predict    (branch_predict),
    .flush             (flush),
    .jump_address      (jump_address)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog: run did not finish within %0d ns", TIMEOUT_NS);
    $display("TESTBENCH FAILED");
    $fatal(1, "timeout");
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < count; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  function automatic jmp_op_e pick_conditional(input logic [2:0] sel);
    case (sel)
      3'd0:    return JMP_OP_JEQ;
      3'd1:    return JMP_OP_JNE;
      3'd2:    return JMP_OP_JL;
      3'd3:    return JMP_OP_JLE;
      3'd4:    return JMP_OP_JG;
      3'd5:    return JMP_OP_JGE;
      3'd6:    return JMP_OP_JZ;
      default: return JMP_OP_JNZ;
    endcase
  endfunction

  function automatic logic is_conditional(input jmp_op_e op);
    return op inside {JMP_OP_JEQ, JMP_OP_JNE, JMP_OP_JL, JMP_OP_JLE,
                      JMP_OP_JG, JMP_OP_JGE, JMP_OP_JZ, JMP_OP_JNZ};
  endfunction

  function automatic logic cond_holds(input jmp_op_e op, input logic z, input logic l,
                                      input logic g);
    if (op == JMP_OP_JEQ || op == JMP_OP_JZ) return z;
    if (op == JMP_OP_JNE || op == JMP_OP_JNZ) return !z;
    if (op == JMP_OP_JL) return l;
    if (op == JMP_OP_JLE) return l | z;
    if (op == JMP_OP_JG) return g;
    if (op == JMP_OP_JGE) return g | z;
    return 1'b0;
  endfunction

  task automatic report_mismatch(input string what, input string expected, input string actual);
    $display("ERR %s %s: expected %s actual %s", test_name, what, expected, actual);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic drive_execute(
    input jmp_op_e                op,
    input logic                   z,
    input logic                   l,
    input logic                   g,
    input logic                   predicted,
    input logic [`ADDR_WIDTH-1:0] at_pc,
    input logic [`ADDR_WIDTH-1:0] reg_addr,
    input logic [`ADDR_WIDTH-1:0] imm_addr
  );
    @(posedge clk);
    #2;
    jop               = op;
    zero              = z;
    less              = l;
    greater           = g;
    branch_taken      = predicted;
    id_ex_pc          = at_pc;
    id_ex_reg_address = reg_addr;
    id_ex_imm_address = imm_addr;
  endtask

  task automatic drive_nop();
    drive_execute(JMP_OP_NOP, 1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic check_pc(input logic [`ADDR_WIDTH-1:0] want);
    assert (pc == want)
      else report_mismatch("pc", $sformatf("%h", want), $sformatf("%h", pc));
  endtask

  task automatic check_hit(input logic want_hit, input logic [`ADDR_WIDTH-1:0] want_target);
    assert (take_branch == want_hit)
      else report_mismatch("take_branch", $sformatf("%b", want_hit), $sformatf("%b", take_branch));
    if (want_hit) begin
      assert (branch_predict == want_target)
        else report_mismatch("branch_predict", $sformatf("%h", want_target),
                             $sformatf("%h", branch_predict));
    end
  endtask

  task automatic check_resolve(input logic [`NUM_PIPE_MASKS-1:0] want_flush,
                               input logic [`ADDR_WIDTH-1:0] want_jump);
    assert (flush == want_flush)
      else report_mismatch("flush", $sformatf("%h", want_flush), $sformatf("%h", flush));
    assert (jump_address == want_jump)
      else report_mismatch("jump_address", $sformatf("%h", want_jump),
                           $sformatf("%h", jump_address));
  endtask

  // ----------------------------------------
  // Reference model, sampled mid-cycle
  // ----------------------------------------

  always @(negedge clk) begin
    if (rst) begin
      for (int i = 0; i < `LUT_ENTRIES; i++) begin
        shadow_valid[i] = 1'b0;
      end
      exp_pc = '0;
    end else begin
      mispredicted = is_conditional(jop) &&
                     (cond_holds(jop, zero, less, greater) != branch_taken);
      if (jop == JMP_OP_JR || mispredicted) exp_flush = PIPE_FLUSH_ALL;
      else if (jop == JMP_OP_J) exp_flush = PIPE_REG_EX_MEM;
      else exp_flush = '0;
      if (jop == JMP_OP_JR) exp_jump = id_ex_reg_address;
      else if (mispredicted && branch_taken) exp_jump = id_ex_pc + ADDR_ONE;
      else exp_jump = id_ex_imm_address;

      rd_idx      = exp_pc[INDEX_BITS-1:0];
      exp_take    = shadow_valid[rd_idx] &&
                    (shadow_tag[rd_idx] == exp_pc[`ADDR_WIDTH-1:INDEX_BITS]);
      exp_predict = shadow_target[rd_idx];

      check_pc(exp_pc);
      check_resolve(exp_flush, exp_jump);
      check_hit(exp_take, exp_predict);

      if (exp_flush[0]) exp_pc = exp_jump;
      else if (exp_take) exp_pc = exp_predict;
      else exp_pc = exp_pc + ADDR_ONE;

      if (exp_flush == PIPE_FLUSH_ALL) begin  // Lands at the next edge
        wr_idx = id_ex_pc[INDEX_BITS-1:0];
        shadow_valid[wr_idx]  = (jop == JMP_OP_JR) || (mispredicted && !branch_taken);
        shadow_tag[wr_idx]    = id_ex_pc[`ADDR_WIDTH-1:INDEX_BITS];
        shadow_target[wr_idx] = exp_jump;
      end
    end
  end

  nop_no_flush: assert property (@(posedge clk) disable iff (rst)
    (jop == JMP_OP_NOP) |-> (flush == '0))
    else report_mismatch("flush on NOP", "0", $sformatf("%h", $sampled(flush)));

  j_flush_ex_mem: assert property (@(posedge clk) disable iff (rst)
    (jop == JMP_OP_J) |-> (flush == PIPE_REG_EX_MEM))
    else report_mismatch("flush on J", $sformatf("%h", PIPE_REG_EX_MEM),
                         $sformatf("%h", $sampled(flush)));

  jr_redirects: assert property (@(posedge clk) disable iff (rst)
    ($past(jop) == JMP_OP_JR) |-> (pc == $past(id_ex_reg_address)))
    else report_mismatch("pc after JR", $sformatf("%h", $past(id_ex_reg_address)),
                         $sformatf("%h", $sampled(pc)));

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  initial begin
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    lfsr_state        = 32'd99317;
    test_name         = "reset";
    rst               = 1'b1;
    jop               = JMP_OP_NOP;
    zero              = 1'b0;
    less              = 1'b0;
    greater           = 1'b0;
    branch_taken      = 1'b0;
    id_ex_pc          = '0;
    id_ex_reg_address = '0;
    id_ex_imm_address = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;

    test_name = "sequential_fetch";
    @(negedge clk);
    check_pc('0);
    for (int n = 0; n < SEQ_CYCLES; n++) begin
      drive_nop();
      @(negedge clk);
      check_pc(`ADDR_WIDTH'(n + 1));
      check_hit(1'b0, '0);
    end

    test_name = "conditional_resolution";
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r = random_bits(7);  // Opcode select, three flags, prediction
      a = random_bits(16);
      b = random_bits(16);
      c = random_bits(16);
      drive_execute(pick_conditional(r[2:0]), r[3], r[4], r[5], r[6],
                    a[`ADDR_WIDTH-1:0], b[`ADDR_WIDTH-1:0], c[`ADDR_WIDTH-1:0]);
    end

    test_name = "register_jump";
    repeat (4) begin
      a = random_bits(16);
      drive_execute(JMP_OP_JR, 1'b0, 1'b0, 1'b0, 1'b0, JR_SITE, a[`ADDR_WIDTH-1:0], '0);
      @(negedge clk);
      check_resolve(PIPE_FLUSH_ALL, a[`ADDR_WIDTH-1:0]);
      drive_nop();
      @(negedge clk);
      check_pc(a[`ADDR_WIDTH-1:0]);
    end

    test_name = "learn_target";
    drive_execute(JMP_OP_JEQ, 1'b1, 1'b0, 1'b0, 1'b0, LEARN_PC, '0, TARGET);
    @(negedge clk);
    check_resolve(PIPE_FLUSH_ALL, TARGET);
    drive_execute(JMP_OP_JR, 1'b0, 1'b0, 1'b0, 1'b0, JR_SITE, LEARN_PC, '0);
    drive_nop();
    @(negedge clk);
    check_pc(LEARN_PC);
    check_hit(1'b1, TARGET);
    drive_nop();
    @(negedge clk);
    check_pc(TARGET);

    test_name = "alias_miss";
    drive_execute(JMP_OP_JR, 1'b0, 1'b0, 1'b0, 1'b0, JR_SITE, ALIAS_PC, '0);
    drive_nop();
    @(negedge clk);
    check_pc(ALIAS_PC);
    check_hit(1'b0, '0);
    drive_nop();
    @(negedge clk);
    check_pc(ALIAS_PC + ADDR_ONE);

    test_name = "unlearn_target";
    drive_execute(JMP_OP_JEQ, 1'b0, 1'b0, 1'b0, 1'b1, LEARN_PC, '0, TARGET);
    @(negedge clk);
    check_resolve(PIPE_FLUSH_ALL, LEARN_PC + ADDR_ONE);
    drive_execute(JMP_OP_JR, 1'b0, 1'b0, 1'b0, 1'b0, JR_SITE, LEARN_PC, '0);
    drive_nop();
    @(negedge clk);
    check_pc(LEARN_PC);
    check_hit(1'b0, '0);
    drive_nop();
    @(negedge clk);
    check_pc(LEARN_PC + ADDR_ONE);

    test_name = "decoder_jump";
    repeat (8) begin
      a = random_bits(16);
      c = random_bits(16);
      drive_execute(JMP_OP_J, 1'b0, 1'b0, 1'b0, 1'b0, a[`ADDR_WIDTH-1:0], '0,
                    c[`ADDR_WIDTH-1:0]);
      @(negedge clk);
      check_resolve(PIPE_REG_EX_MEM, c[`ADDR_WIDTH-1:0]);
    end

    test_name = "drain";
    drive_nop();
    drive_nop();
    @(negedge clk);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
hdl/branch_pkg.sv
hdl/target_lut.sv
hdl/branch_unit.sv
hdl/fetch_pc.sv
hdl/branch_frontend.sv
tb/tb_branch_frontend.sv

//--- Makefile
TOP = tb_branch_frontend

.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/1ns --top-module $(TOP) -f build.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
